// ==== include/ex_params.svh ====
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// architectural widths of the execute stage

// data word, one gpr
`define EX_WORD_W 32

// shift amount taken from the low bits of operand 1
`define EX_SHAMT_W 5

// destination register index
`define EX_REG_ADDR_W 5

// madd/msub execute cycles
// step 0 registers the product, the last step adds hi/lo
`define EX_ACC_STEPS 2

`endif

// ==== hdl/ex_pkg.sv ====
`include "ex_params.svh"

package ex_pkg;

    typedef logic [`EX_WORD_W-1:0]     word_t;
    typedef logic [2*`EX_WORD_W-1:0]   dword_t;     // product and {hi, lo}
    typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [4:0] {
        OP_NOP   = 5'd0,
        OP_OR    = 5'd1,
        OP_AND   = 5'd2,
        OP_NOR   = 5'd3,
        OP_XOR   = 5'd4,
        OP_SLL   = 5'd5,
        OP_SRL   = 5'd6,
        OP_SRA   = 5'd7,
        OP_ADD   = 5'd8,        // traps write on overflow
        OP_ADDU  = 5'd9,
        OP_SUB   = 5'd10,       // traps write on overflow
        OP_SUBU  = 5'd11,
        OP_SLT   = 5'd12,
        OP_SLTU  = 5'd13,
        OP_CLZ   = 5'd14,
        OP_CLO   = 5'd15,
        OP_MUL   = 5'd16,       // low word to gpr only
        OP_MULT  = 5'd17,
        OP_MULTU = 5'd18,
        OP_MADD  = 5'd19,
        OP_MADDU = 5'd20,
        OP_MSUB  = 5'd21,
        OP_MSUBU = 5'd22,
        OP_MFHI  = 5'd23,
        OP_MFLO  = 5'd24,
        OP_MTHI  = 5'd25,
        OP_MTLO  = 5'd26
    } aluop_e;

    typedef enum logic [2:0] {
        CLS_NONE  = 3'd0,
        CLS_LOGIC = 3'd1,
        CLS_SHIFT = 3'd2,
        CLS_ARITH = 3'd3,
        CLS_MOVE  = 3'd4,
        CLS_MUL   = 3'd5
    } res_class_e;

    // which unit feeds the gpr write data
    function automatic res_class_e op_class(input aluop_e op);
        res_class_e cls;
        case (op)
            OP_OR, OP_AND, OP_NOR, OP_XOR: cls = CLS_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:        cls = CLS_SHIFT;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
            OP_SLT, OP_SLTU, OP_CLZ, OP_CLO: cls = CLS_ARITH;
            OP_MFHI, OP_MFLO:              cls = CLS_MOVE;
            OP_MUL:                        cls = CLS_MUL;
            default:                       cls = CLS_NONE;  // hi/lo only or nop
        endcase
        return cls;
    endfunction

endpackage

// ==== hdl/ex_alu.sv ====
`timescale 1ns/1ps
`include "ex_params.svh"

module ex_alu
    import ex_pkg::*;
(
    input  aluop_e aluop_i,
    input  word_t  reg1_i,
    input  word_t  reg2_i,
    output word_t  logic_res_o,
    output word_t  shift_res_o,
    output word_t  arith_res_o,
    output logic   ovf_o
);

    logic [`EX_SHAMT_W-1:0] shamt;
    logic                   sub_sel;
    word_t                  opnd2;
    logic [`EX_WORD_W:0]    sum_ext;    // carry out on top
    word_t                  sum;
    logic                   lt_signed;
    logic                   lt_unsigned;
    logic [5:0]             clz_cnt;
    logic [5:0]             clo_cnt;

    // leading zero count, 0..32
    function automatic logic [5:0] lead_zeros(input word_t v);
        logic [5:0] n;
        logic       seen;
        n    = 6'd0;
        seen = 1'b0;
        for (int i = `EX_WORD_W - 1; i >= 0; i--) begin
            if (v[i]) begin
                seen = 1'b1;
            end else if (!seen) begin
                n = n + 6'd1;
            end
        end
        return n;
    endfunction

    always_comb begin
        case (aluop_i)
            OP_OR:   logic_res_o = reg1_i | reg2_i;
            OP_AND:  logic_res_o = reg1_i & reg2_i;
            OP_NOR:  logic_res_o = ~(reg1_i | reg2_i);
            OP_XOR:  logic_res_o = reg1_i ^ reg2_i;
            default: logic_res_o = '0;
        endcase
    end

    assign shamt = reg1_i[`EX_SHAMT_W-1:0];

    // operand 2 is the value shifted
    always_comb begin
        case (aluop_i)
            OP_SLL:  shift_res_o = reg2_i << shamt;
            OP_SRL:  shift_res_o = reg2_i >> shamt;
            OP_SRA:  shift_res_o = $signed(reg2_i) >>> shamt;   // sign fill
            default: shift_res_o = '0;
        endcase
    end

    // single adder, subtract as a + ~b + 1
    assign sub_sel = aluop_i inside {OP_SUB, OP_SUBU, OP_SLT, OP_SLTU};
    assign opnd2   = sub_sel ? ~reg2_i : reg2_i;
    assign sum_ext = {1'b0, reg1_i} + {1'b0, opnd2} + {{`EX_WORD_W{1'b0}}, sub_sel};
    assign sum     = sum_ext[`EX_WORD_W-1:0];

    // same effective signs in, other sign out
    assign ovf_o = (reg1_i[`EX_WORD_W-1] == opnd2[`EX_WORD_W-1]) &&
                   (sum[`EX_WORD_W-1] != reg1_i[`EX_WORD_W-1]);

    // mixed signs decide directly, else the difference sign
    assign lt_signed = (reg1_i[`EX_WORD_W-1] && !reg2_i[`EX_WORD_W-1]) ||
                       ((reg1_i[`EX_WORD_W-1] == reg2_i[`EX_WORD_W-1]) &&
                        sum[`EX_WORD_W-1]);
    assign lt_unsigned = !sum_ext[`EX_WORD_W];  // borrow

    assign clz_cnt = lead_zeros(reg1_i);
    // clo is clz of the inverted operand
    assign clo_cnt = lead_zeros(~reg1_i);

    always_comb begin
        case (aluop_i)
            OP_ADD, OP_ADDU,
            OP_SUB, OP_SUBU: arith_res_o = sum;
            OP_SLT:          arith_res_o = {{(`EX_WORD_W-1){1'b0}}, lt_signed};
            OP_SLTU:         arith_res_o = {{(`EX_WORD_W-1){1'b0}}, lt_unsigned};
            OP_CLZ:          arith_res_o = {{(`EX_WORD_W-6){1'b0}}, clz_cnt};
            OP_CLO:          arith_res_o = {{(`EX_WORD_W-6){1'b0}}, clo_cnt};
            default:         arith_res_o = '0;
        endcase
    end

endmodule

// ==== hdl/ex_mult.sv ====
`timescale 1ns/1ps
`include "ex_params.svh"

module ex_mult
    import ex_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   valid_i,
    input  aluop_e aluop_i,
    input  word_t  reg1_i,
    input  word_t  reg2_i,
    input  word_t  hi_i,        // forwarded hi/lo
    input  word_t  lo_i,
    output dword_t prod_o,
    output dword_t acc_res_o,
    output logic   stall_o
);

    localparam int STEP_W = $clog2(`EX_ACC_STEPS);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`EX_ACC_STEPS - 1);

    logic              is_signed;
    logic              is_acc;
    logic              is_msub;
    word_t             opa;
    word_t             opb;
    dword_t            prod_mag;
    dword_t            prod;
    logic [STEP_W-1:0] step_q;
    dword_t            acc_prod_q;  // product, already negated for msub

    assign is_signed = aluop_i inside {OP_MUL, OP_MULT, OP_MADD, OP_MSUB};
    assign is_acc    = aluop_i inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    assign is_msub   = aluop_i inside {OP_MSUB, OP_MSUBU};

    // multiply magnitudes, fix the sign afterwards
    assign opa      = (is_signed && reg1_i[`EX_WORD_W-1]) ? -reg1_i : reg1_i;
    assign opb      = (is_signed && reg2_i[`EX_WORD_W-1]) ? -reg2_i : reg2_i;
    assign prod_mag = opa * opb;
    assign prod     = (is_signed && (reg1_i[`EX_WORD_W-1] ^ reg2_i[`EX_WORD_W-1])) ?
                      -prod_mag : prod_mag;
    assign prod_o   = prod;

    // step counter, last step is the accepting one
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            step_q <= '0;
        end else if (valid_i && is_acc) begin
            if (step_q == LAST_STEP) begin
                step_q <= '0;           // accepted at this edge
            end else begin
                step_q <= step_q + 1'b1;
            end
        end else begin
            step_q <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i && is_acc && (step_q == '0)) begin
            acc_prod_q <= is_msub ? -prod : prod;
        end
    end

    // hi/lo is read in the last step so a pending write has landed
    assign acc_res_o = acc_prod_q + {hi_i, lo_i};
    assign stall_o   = valid_i && is_acc && (step_q != LAST_STEP);

    // one stall cycle per accumulate op
    a_stall_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_o |=> (!stall_o || $changed(aluop_i) ||
                     $changed(reg1_i) || $changed(reg2_i)))
        else $error("ex_mult: stall held two cycles on stable inputs");

endmodule

// ==== hdl/hilo_regs.sv ====
`timescale 1ns/1ps

module hilo_regs
    import ex_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  whilo_i,      // from stage output register
    input  word_t hi_i,
    input  word_t lo_i,
    output word_t hi_o,
    output word_t lo_o
);

    word_t hi_q;
    word_t lo_q;

    // architectural state, zero after reset
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (whilo_i) begin
            hi_q <= hi_i;
            lo_q <= lo_i;
        end
    end

    // pending write bypasses storage
    // so an op right behind mthi/mtlo/mult sees the new pair
    assign hi_o = whilo_i ? hi_i : hi_q;
    assign lo_o = whilo_i ? lo_i : lo_q;

    // an x here would corrupt both hi and lo silently
    a_whilo_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$isunknown(whilo_i))
        else $error("hilo_regs: whilo_i unknown");

endmodule

// ==== hdl/ex_stage.sv ====
`timescale 1ns/1ps
`include "ex_params.svh"

module ex_stage
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      valid_i,
    input  aluop_e    aluop_i,
    input  word_t     reg1_i,
    input  word_t     reg2_i,
    input  reg_addr_t wd_i,
    input  logic      wreg_i,
    output logic      stall_o,
    output logic      valid_o,
    output reg_addr_t wd_o,
    output logic      wreg_o,
    output word_t     wdata_o,
    output logic      whilo_o,
    output word_t     hi_o,
    output word_t     lo_o
);

    logic       accept;
    res_class_e res_class;
    word_t      logic_res;
    word_t      shift_res;
    word_t      arith_res;
    logic       ovf;
    dword_t     prod;
    dword_t     acc_res;
    word_t      hi_fwd;         // newest hi/lo, pending write included
    word_t      lo_fwd;
    word_t      wdata_nxt;
    logic       wreg_nxt;
    logic       whilo_nxt;
    word_t      hi_nxt;
    word_t      lo_nxt;

    ex_alu u_ex_alu (
        .aluop_i     (aluop_i),
        .reg1_i      (reg1_i),
        .reg2_i      (reg2_i),
        .logic_res_o (logic_res),
        .shift_res_o (shift_res),
        .arith_res_o (arith_res),
        .ovf_o       (ovf)
    );

    ex_mult u_ex_mult (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .valid_i   (valid_i),
        .aluop_i   (aluop_i),
        .reg1_i    (reg1_i),
        .reg2_i    (reg2_i),
        .hi_i      (hi_fwd),
        .lo_i      (lo_fwd),
        .prod_o    (prod),
        .acc_res_o (acc_res),
        .stall_o   (stall_o)
    );

    hilo_regs u_hilo_regs (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .whilo_i (whilo_o),
        .hi_i    (hi_o),
        .lo_i    (lo_o),
        .hi_o    (hi_fwd),
        .lo_o    (lo_fwd)
    );

    assign accept    = valid_i && !stall_o;
    assign res_class = op_class(aluop_i);

    always_comb begin
        case (res_class)
            CLS_LOGIC: wdata_nxt = logic_res;
            CLS_SHIFT: wdata_nxt = shift_res;
            CLS_ARITH: wdata_nxt = arith_res;
            CLS_MOVE:  wdata_nxt = (aluop_i == OP_MFHI) ? hi_fwd : lo_fwd;
            CLS_MUL:   wdata_nxt = prod[`EX_WORD_W-1:0];
            default:   wdata_nxt = '0;
        endcase
    end

    // signed add/sub drop the write on overflow
    assign wreg_nxt = ((aluop_i == OP_ADD) || (aluop_i == OP_SUB)) && ovf ? 1'b0 : wreg_i;

    always_comb begin
        whilo_nxt = 1'b1;
        case (aluop_i)
            OP_MULT, OP_MULTU:  {hi_nxt, lo_nxt} = prod;
            OP_MADD, OP_MADDU,
            OP_MSUB, OP_MSUBU:  {hi_nxt, lo_nxt} = acc_res;
            OP_MTHI:            {hi_nxt, lo_nxt} = {reg1_i, lo_fwd};
            OP_MTLO:            {hi_nxt, lo_nxt} = {hi_fwd, reg1_i};
            default: begin
                whilo_nxt        = 1'b0;
                {hi_nxt, lo_nxt} = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            wreg_o  <= 1'b0;
            whilo_o <= 1'b0;
        end else begin
            valid_o <= accept;
            wreg_o  <= accept && wreg_nxt;
            whilo_o <= accept && whilo_nxt;    // bubble writes nothing
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wd_o    <= wd_i;
            wdata_o <= wdata_nxt;
            hi_o    <= hi_nxt;
            lo_o    <= lo_nxt;
        end
    end

    a_wreg_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        wreg_o |-> valid_o)
        else $error("ex_stage: register write without valid");

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release on a falling edge, away from the active edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== testbench/tb_ex_stage.sv ====
`timescale 1ns/1ps

module tb_ex_stage
    import ex_pkg::*;
();

    localparam int N_DIRECTED  = 35;
    localparam int N_RANDOM    = 64;
    localparam int TIMEOUT_CYC = 3 * (N_DIRECTED + N_RANDOM) + 50;

    typedef struct {
        aluop_e    op;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
        word_t     exp_wdata;
        logic      exp_wreg;
        logic      exp_whilo;
        word_t     exp_hi;
        word_t     exp_lo;
    } row_t;

    logic      clk;
    logic      rst_n;
    logic      valid_i;
    aluop_e    aluop_i;
    word_t     reg1_i;
    word_t     reg2_i;
    reg_addr_t wd_i;
    logic      wreg_i;
    logic      stall_o;
    logic      valid_o;
    reg_addr_t wd_o;
    logic      wreg_o;
    word_t     wdata_o;
    logic      whilo_o;
    word_t     hi_o;
    word_t     lo_o;

    row_t      table_q [N_DIRECTED];
    aluop_e    rand_ops [13] = '{OP_OR, OP_AND, OP_NOR, OP_XOR, OP_SLL, OP_SRL, OP_SRA,
                                 OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU};
    logic [31:0] lfsr_q;
    int        err_cnt;
    int        tests_ok;
    int        tests_bad;
    int        cyc;

    tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(5)) u_tb_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    ex_stage u_ex_stage (
        .clk     (clk),
        .rst_n_i (rst_n),
        .valid_i (valid_i),
        .aluop_i (aluop_i),
        .reg1_i  (reg1_i),
        .reg2_i  (reg2_i),
        .wd_i    (wd_i),
        .wreg_i  (wreg_i),
        .stall_o (stall_o),
        .valid_o (valid_o),
        .wd_o    (wd_o),
        .wreg_o  (wreg_o),
        .wdata_o (wdata_o),
        .whilo_o (whilo_o),
        .hi_o    (hi_o),
        .lo_o    (lo_o)
    );

    // galois form, one step per bit
    function automatic logic lfsr_bit();
        logic out;
        out    = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic row_t mk_row(input aluop_e op, input word_t r1, input word_t r2,
                                    input reg_addr_t wd, input logic wreg,
                                    input word_t wdata, input logic ewreg,
                                    input logic ewhilo, input word_t hi, input word_t lo);
        row_t r;
        r = '{op, r1, r2, wd, wreg, wdata, ewreg, ewhilo, hi, lo};
        return r;
    endfunction

    // reference for the single-cycle gpr ops
    function automatic row_t model_row(input row_t r);
        longint s;
        r.exp_wreg  = r.wreg;
        r.exp_whilo = 1'b0;
        r.exp_hi    = '0;
        r.exp_lo    = '0;
        r.exp_wdata = '0;
        case (op_class(r.op))
            CLS_LOGIC: begin
                case (r.op)
                    OP_OR:   r.exp_wdata = r.reg1 | r.reg2;
                    OP_AND:  r.exp_wdata = r.reg1 & r.reg2;
                    OP_NOR:  r.exp_wdata = ~(r.reg1 | r.reg2);
                    default: r.exp_wdata = r.reg1 ^ r.reg2;
                endcase
            end
            CLS_SHIFT: begin
                case (r.op)
                    OP_SLL:  r.exp_wdata = r.reg2 << r.reg1[4:0];
                    OP_SRL:  r.exp_wdata = r.reg2 >> r.reg1[4:0];
                    default: r.exp_wdata = $signed(r.reg2) >>> r.reg1[4:0];
                endcase
            end
            CLS_ARITH: begin
                if (r.op inside {OP_ADD, OP_ADDU}) begin
                    s = longint'($signed(r.reg1)) + longint'($signed(r.reg2));
                end else begin
                    s = longint'($signed(r.reg1)) - longint'($signed(r.reg2));
                end
                case (r.op)
                    OP_SLT:  r.exp_wdata = ($signed(r.reg1) < $signed(r.reg2)) ? 32'd1 : 32'd0;
                    OP_SLTU: r.exp_wdata = (r.reg1 < r.reg2) ? 32'd1 : 32'd0;
                    default: r.exp_wdata = s[31:0];
                endcase
                // result does not fit in 32 signed bits
                if ((r.op inside {OP_ADD, OP_SUB}) && (s != longint'($signed(s[31:0])))) begin
                    r.exp_wreg = 1'b0;
                end
            end
            default: r.exp_wdata = '0;
        endcase
        return r;
    endfunction

    task automatic fill_table();
        table_q[0]  = mk_row(OP_MFHI,  32'h0,        32'h0,        5'd1,  1, 32'h0,        1, 0, 0, 0);
        table_q[1]  = mk_row(OP_OR,    32'h12345678, 32'h0F0FF0F0, 5'd2,  1, 32'h1F3FF6F8, 1, 0, 0, 0);
        table_q[2]  = mk_row(OP_AND,   32'h12345678, 32'h0F0FF0F0, 5'd3,  1, 32'h02045070, 1, 0, 0, 0);
        table_q[3]  = mk_row(OP_NOR,   32'h12345678, 32'h0F0FF0F0, 5'd4,  1, 32'hE0C00907, 1, 0, 0, 0);
        table_q[4]  = mk_row(OP_XOR,   32'h12345678, 32'h0F0FF0F0, 5'd5,  1, 32'h1D3BA688, 1, 0, 0, 0);
        table_q[5]  = mk_row(OP_SLL,   32'hFFFFFFE4, 32'h80000001, 5'd6,  1, 32'h00000010, 1, 0, 0, 0);
        table_q[6]  = mk_row(OP_SRL,   32'h00000008, 32'h80000000, 5'd7,  1, 32'h00800000, 1, 0, 0, 0);
        table_q[7]  = mk_row(OP_SRA,   32'h00000008, 32'h80000000, 5'd8,  1, 32'hFF800000, 1, 0, 0, 0);
        table_q[8]  = mk_row(OP_SRA,   32'h0000001F, 32'h80000000, 5'd9,  1, 32'hFFFFFFFF, 1, 0, 0, 0);
        table_q[9]  = mk_row(OP_CLZ,   32'h00000000, 32'h0,        5'd10, 1, 32'h00000020, 1, 0, 0, 0);
        table_q[10] = mk_row(OP_CLZ,   32'h00010000, 32'h0,        5'd11, 1, 32'h0000000F, 1, 0, 0, 0);
        table_q[11] = mk_row(OP_CLO,   32'hFFFFFFFF, 32'h0,        5'd12, 1, 32'h00000020, 1, 0, 0, 0);
        table_q[12] = mk_row(OP_CLO,   32'hF0000000, 32'h0,        5'd13, 1, 32'h00000004, 1, 0, 0, 0);
        table_q[13] = mk_row(OP_ADD,   32'h7FFFFFFF, 32'h00000001, 5'd14, 1, 32'h80000000, 0, 0, 0, 0);
        table_q[14] = mk_row(OP_ADDU,  32'h7FFFFFFF, 32'h00000001, 5'd15, 1, 32'h80000000, 1, 0, 0, 0);
        table_q[15] = mk_row(OP_SUB,   32'h80000000, 32'h00000001, 5'd16, 1, 32'h7FFFFFFF, 0, 0, 0, 0);
        table_q[16] = mk_row(OP_SUBU,  32'h80000000, 32'h00000001, 5'd17, 1, 32'h7FFFFFFF, 1, 0, 0, 0);
        table_q[17] = mk_row(OP_ADD,   32'h00000005, 32'hFFFFFFFD, 5'd18, 1, 32'h00000002, 1, 0, 0, 0);
        table_q[18] = mk_row(OP_SLT,   32'hFFFFFFFF, 32'h00000001, 5'd19, 1, 32'h00000001, 1, 0, 0, 0);
        table_q[19] = mk_row(OP_SLTU,  32'hFFFFFFFF, 32'h00000001, 5'd20, 1, 32'h00000000, 1, 0, 0, 0);
        table_q[20] = mk_row(OP_SLT,   32'h00000001, 32'hFFFFFFFF, 5'd21, 1, 32'h00000000, 1, 0, 0, 0);
        table_q[21] = mk_row(OP_SLTU,  32'h00000001, 32'hFFFFFFFF, 5'd22, 1, 32'h00000001, 1, 0, 0, 0);
        table_q[22] = mk_row(OP_MUL,   32'hFFFFFFFE, 32'h00000003, 5'd23, 1, 32'hFFFFFFFA, 1, 0, 0, 0);
        table_q[23] = mk_row(OP_MULT,  32'hFFFFFFFE, 32'h00000003, 5'd0,  0, 32'h0, 0, 1,
                             32'hFFFFFFFF, 32'hFFFFFFFA);
        table_q[24] = mk_row(OP_MULTU, 32'hFFFFFFFE, 32'h00000003, 5'd0,  0, 32'h0, 0, 1,
                             32'h00000002, 32'hFFFFFFFA);
        // mtlo reads hi from the pending mthi write
        table_q[25] = mk_row(OP_MTHI,  32'hAAAA5555, 32'h0, 5'd0, 0, 32'h0, 0, 1,
                             32'hAAAA5555, 32'hFFFFFFFA);
        table_q[26] = mk_row(OP_MTLO,  32'h1234ABCD, 32'h0, 5'd0, 0, 32'h0, 0, 1,
                             32'hAAAA5555, 32'h1234ABCD);
        table_q[27] = mk_row(OP_MFHI,  32'h0, 32'h0, 5'd24, 1, 32'hAAAA5555, 1, 0, 0, 0);
        table_q[28] = mk_row(OP_MFLO,  32'h0, 32'h0, 5'd25, 1, 32'h1234ABCD, 1, 0, 0, 0);
        // accumulate chain starting from 42
        table_q[29] = mk_row(OP_MULT,  32'h7, 32'h6, 5'd0, 0, 32'h0, 0, 1, 32'h0, 32'h2A);
        table_q[30] = mk_row(OP_MADD,  32'h00010000, 32'h00010000, 5'd0, 0, 32'h0, 0, 1,
                             32'h1, 32'h2A);
        table_q[31] = mk_row(OP_MSUB,  32'hFFFFFFFF, 32'h10, 5'd0, 0, 32'h0, 0, 1, 32'h1, 32'h3A);
        table_q[32] = mk_row(OP_MADDU, 32'hFFFFFFFF, 32'h2, 5'd0, 0, 32'h0, 0, 1, 32'h3, 32'h38);
        table_q[33] = mk_row(OP_MSUBU, 32'h3, 32'h4, 5'd0, 0, 32'h0, 0, 1, 32'h3, 32'h2C);
        table_q[34] = mk_row(OP_MFHI,  32'h0, 32'h0, 5'd26, 1, 32'h00000003, 1, 0, 0, 0);
    endtask

    // entered and left on a falling edge
    task automatic run_row(input row_t r, input int idx);
        int   lat;
        int   stalls;
        int   exp_lat;
        int   err_before;
        logic is_acc;
        err_before = err_cnt;
        is_acc     = r.op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
        exp_lat    = is_acc ? 2 : 1;
        valid_i    = 1'b1;
        aluop_i    = r.op;
        reg1_i     = r.reg1;
        reg2_i     = r.reg2;
        wd_i       = r.wd;
        wreg_i     = r.wreg;
        lat        = 0;
        stalls     = 0;
        do begin
            #1;
            if (stall_o) stalls++;     // settled value that gates the coming edge
            @(posedge clk);
            @(negedge clk);
            lat++;
        end while (!valid_o && lat < 4);
        if (!valid_o) begin
            $display("row %0d (%s) never produced valid_o", idx, r.op.name());
            err_cnt++;
        end else begin
            if (lat != exp_lat) begin
                $display("FAIL t=%0t row %0d %s: latency %0d, expected %0d",
                         $time, idx, r.op.name(), lat, exp_lat);
                err_cnt++;
            end
            if (stalls != (is_acc ? 1 : 0)) begin
                $display("FAIL t=%0t row %0d %s: %0d stall cycles", $time, idx, r.op.name(), stalls);
                err_cnt++;
            end
            if (op_class(r.op) != CLS_NONE && wdata_o !== r.exp_wdata) begin
                $display("FAIL t=%0t row %0d %s: wdata_o %h, expected %h",
                         $time, idx, r.op.name(), wdata_o, r.exp_wdata);
                err_cnt++;
            end
            if (wreg_o !== r.exp_wreg || wd_o !== r.wd) begin
                $display("FAIL t=%0t row %0d %s: wreg_o %b wd_o %0d, expected %b %0d",
                         $time, idx, r.op.name(), wreg_o, wd_o, r.exp_wreg, r.wd);
                err_cnt++;
            end
            if (whilo_o !== r.exp_whilo) begin
                $display("FAIL t=%0t row %0d %s: whilo_o %b, expected %b",
                         $time, idx, r.op.name(), whilo_o, r.exp_whilo);
                err_cnt++;
            end
            if (r.exp_whilo && (hi_o !== r.exp_hi || lo_o !== r.exp_lo)) begin
                $display("FAIL t=%0t row %0d %s: hi/lo %h_%h, expected %h_%h",
                         $time, idx, r.op.name(), hi_o, lo_o, r.exp_hi, r.exp_lo);
                err_cnt++;
            end
        end
        if (err_cnt == err_before) begin
            tests_ok++;
            $display("test %0d %s ok", idx, r.op.name());
        end else begin
            tests_bad++;
            $display("test %0d %s failed", idx, r.op.name());
        end
    endtask

    initial begin : watchdog
        cyc = 0;
        while (cyc < TIMEOUT_CYC) begin
            @(posedge clk);
            cyc++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        row_t r;
        valid_i   = 1'b0;
        aluop_i   = OP_NOP;
        reg1_i    = '0;
        reg2_i    = '0;
        wd_i      = '0;
        wreg_i    = 1'b0;
        lfsr_q    = 32'h11a5;
        err_cnt   = 0;
        tests_ok  = 0;
        tests_bad = 0;
        fill_table();

        @(posedge rst_n);
        @(negedge clk);
        if (valid_o !== 1'b0 || wreg_o !== 1'b0 || whilo_o !== 1'b0 || stall_o !== 1'b0) begin
            $display("FAIL t=%0t reset: valid %b wreg %b whilo %b stall %b, expected all low",
                     $time, valid_o, wreg_o, whilo_o, stall_o);
            err_cnt++;
            tests_bad++;
        end else begin
            tests_ok++;
            $display("test reset ok");
        end

        for (int i = 0; i < N_DIRECTED; i++) begin
            run_row(table_q[i], i);
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            r.op   = rand_ops[rand_bits(4) % 13];
            r.reg1 = rand_bits(32);
            r.reg2 = rand_bits(32);
            r.wd   = reg_addr_t'(rand_bits(5));
            r.wreg = lfsr_bit();
            r      = model_row(r);
            run_row(r, N_DIRECTED + i);
        end

        valid_i = 1'b0;
        @(negedge clk);
        if (valid_o !== 1'b0) begin
            $display("FAIL t=%0t idle: valid_o stayed high with valid_i low", $time);
            err_cnt++;
            tests_bad++;
        end else begin
            tests_ok++;
            $display("test idle ok");
        end

        $display("summary: %0d tests, %0d ok, %0d failed, %0d errors",
                 tests_ok + tests_bad, tests_ok, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/hilo_regs.sv
hdl/ex_stage.sv
testbench/tb_clk_gen.sv
testbench/tb_ex_stage.sv

// ==== Bender.yml ====
package:
  name: ex_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/ex_pkg.sv
      - hdl/ex_alu.sv
      - hdl/ex_mult.sv
      - hdl/hilo_regs.sv
      - hdl/ex_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_ex_stage.sv
